// File: files.f
rtl/conv1x1_pkg.sv
rtl/conv_loop_data_in.sv
rtl/conv_weight_mult.sv
rtl/conv_channel_in_adder.sv
rtl/output_align_fifo.sv
rtl/cnn_conv_1x1.sv
testbench/tb_cnn_conv_1x1.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the 1x1 convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cnn_conv_1x1 -f files.f -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// File: testbench/tb_cnn_conv_1x1.sv
`timescale 1ns/10ps

module tb_cnn_conv_1x1;

	localparam int CIN         = 4;
	localparam int COUT        = 2;
	localparam int FIFO_DEPTH  = 64;
	localparam int START_LEVEL = 8;
	localparam int NUM_PIXELS  = 24;
	localparam int REPLAY      = CIN * COUT;
	localparam int GAP_SPREAD  = 8;
	localparam int MAX_PERIOD  = CIN + REPLAY + GAP_SPREAD;
	localparam int CLK_HALF    = 20;
	localparam int SCALE       = 256;
	localparam int DATA_MAX    = 32767;
	localparam int DATA_MIN    = -32768;
	localparam int TIMEOUT_CYCLES = NUM_PIXELS * MAX_PERIOD + FIFO_DEPTH + 100 + REPLAY + 4;

	logic                     clk;
	logic                     reset;
	conv1x1_pkg::pxl_stream_t pxl_in;
	conv1x1_pkg::pxl_stream_t weight_in;
	conv1x1_pkg::pxl_stream_t pxl_out;

	integer seed;
	int     weights [COUT][CIN];
	int     pixel_vals [CIN];
	int     expected_q [$];
	int     errors;
	int     timeouts;
	int     received;
	int     pixels_sent;

	cnn_conv_1x1 #(
		.CHANNEL_NUM_IN (CIN),
		.CHANNEL_NUM_OUT(COUT),
		.FIFO_DEPTH     (FIFO_DEPTH),
		.START_LEVEL    (START_LEVEL)
	) cnn_conv_1x1_i (
		.clk      (clk),
		.reset    (reset),
		.pxl_in   (pxl_in),
		.weight_in(weight_in),
		.pxl_out  (pxl_out)
	);

	always #CLK_HALF clk = ~clk;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Rounds toward minus infinity
	function automatic longint floor_div(longint num, longint den);
		longint q;
		q = num / den;
		if ((num % den != 0) && (num < 0))
			q = q - 1;
		return q;
	endfunction

	function automatic int clamp_data(longint v);
		if (v > DATA_MAX)
			return DATA_MAX;
		if (v < DATA_MIN)
			return DATA_MIN;
		return int'(v);
	endfunction

	task automatic push_expected();
		longint sum;
		for (int o = 0; o < COUT; o++) begin
			sum = 0;
			for (int i = 0; i < CIN; i++)
				sum = sum + longint'(pixel_vals[i]) * longint'(weights[o][i]);
			expected_q.push_back(clamp_data(floor_div(sum, SCALE)));
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Magnitude of at least 1.0 so extreme pixels always saturate
	task automatic load_weights();
		int mag;
		for (int o = 0; o < COUT; o++) begin
			for (int i = 0; i < CIN; i++) begin
				mag = 256 + ({$random(seed)} % 1024);
				weights[o][i] = ($random(seed) & 1) ? -mag : mag;
				@(posedge clk);
				#2;
				weight_in.valid = 1'b1;
				weight_in.data  = conv1x1_pkg::pixel_t'(weights[o][i]);
			end
		end
		@(posedge clk);
		#2;
		weight_in.valid = 1'b0;
	endtask

	// Mixed small, all negative, push to max and push to min pixels
	task automatic pick_pixel(int p);
		for (int i = 0; i < CIN; i++) begin
			case (p % 6)
				3:       pixel_vals[i] = -1 - ({$random(seed)} % 512);
				4:       pixel_vals[i] = (weights[0][i] >= 0) ? DATA_MAX : DATA_MIN;
				5:       pixel_vals[i] = (weights[0][i] >= 0) ? DATA_MIN : DATA_MAX;
				default: pixel_vals[i] = $random(seed) % 512;
			endcase
		end
	endtask

	task automatic send_pixel();
		int gap;
		push_expected();
		for (int i = 0; i < CIN; i++) begin
			@(posedge clk);
			#2;
			pxl_in.valid = 1'b1;
			pxl_in.data  = conv1x1_pkg::pixel_t'(pixel_vals[i]);
		end
		pixels_sent++;
		gap = REPLAY + ({$random(seed)} % GAP_SPREAD);
		@(posedge clk);
		#2;
		pxl_in.valid = 1'b0;
		repeat (gap - 1) @(posedge clk);
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	always @(negedge clk) begin
		int exp_val;
		if (!reset && pxl_out.valid) begin
			assert (pixels_sent >= START_LEVEL / COUT) else begin
				errors++;
				$display("Output at %0t came before %0d pixels were supplied", $time,
					START_LEVEL / COUT);
			end
			assert (expected_q.size() > 0) else begin
				errors++;
				$display("Output at %0t arrived with no result outstanding", $time);
			end
			if (expected_q.size() > 0) begin
				exp_val = expected_q.pop_front();
				assert (int'(pxl_out.data) == exp_val) else begin
					errors++;
					$display("** Error: time %0t pxl_out.data expected %0d actual %0d",
						$time, exp_val, int'(pxl_out.data));
				end
			end
			received++;
		end
	end

	initial begin
		#(TIMEOUT_CYCLES * 2 * CLK_HALF);
		timeouts++;
		$display("Timeout: the DUT did not deliver all results in time");
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed        = 32'hcc6d332c;
		clk         = 1'b0;
		reset       = 1'b1;
		pxl_in      = '0;
		weight_in   = '0;
		errors      = 0;
		timeouts    = 0;
		received    = 0;
		pixels_sent = 0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		// Quiet output while nothing has been supplied
		repeat (10) begin
			@(negedge clk);
			assert (!pxl_out.valid) else begin
				errors++;
				$display("Output valid rose at %0t with no input supplied", $time);
			end
		end

		load_weights();
		for (int p = 0; p < NUM_PIXELS; p++) begin
			pick_pixel(p);
			send_pixel();
		end

		while (received < NUM_PIXELS * COUT)
			@(posedge clk);
		repeat (20) @(posedge clk);

		assert (expected_q.size() == 0 && received == NUM_PIXELS * COUT) else begin
			errors++;
			$display("Received %0d results, %0d still outstanding", received, expected_q.size());
		end

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: rtl/cnn_conv_1x1.sv
`timescale 1ns/10ps

module cnn_conv_1x1 #(
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 2,
	parameter int FIFO_DEPTH      = 64,
	parameter int START_LEVEL     = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  conv1x1_pkg::pxl_stream_t pxl_in,
	input  conv1x1_pkg::pxl_stream_t weight_in,
	output conv1x1_pkg::pxl_stream_t pxl_out
);

	conv1x1_pkg::pxl_stream_t  loop_out;
	conv1x1_pkg::prod_stream_t prod;
	conv1x1_pkg::pxl_stream_t  sum_out;

	////////////////////////////////////////
	// Replay, multiply, add, align
	////////////////////////////////////////

	conv_loop_data_in #(
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) conv_loop_data_in_i (
		.clk     (clk),
		.reset   (reset),
		.pxl_in  (pxl_in),
		.loop_out(loop_out)
	);

	conv_weight_mult #(
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) conv_weight_mult_i (
		.clk      (clk),
		.reset    (reset),
		.weight_in(weight_in),
		.loop_in  (loop_out),
		.prod     (prod)
	);

	conv_channel_in_adder #(
		.CHANNEL_NUM_IN(CHANNEL_NUM_IN)
	) conv_channel_in_adder_i (
		.clk    (clk),
		.reset  (reset),
		.prod   (prod),
		.sum_out(sum_out)
	);

	// Holds results until a burst of START_LEVEL has gathered
	output_align_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.START_LEVEL(START_LEVEL)
	) output_align_fifo_i (
		.clk    (clk),
		.reset  (reset),
		.wr     (sum_out),
		.pxl_out(pxl_out)
	);

endmodule

// File: rtl/output_align_fifo.sv
`timescale 1ns/10ps

module output_align_fifo #(
	parameter int FIFO_DEPTH  = 64,
	parameter int START_LEVEL = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  conv1x1_pkg::pxl_stream_t wr,
	output conv1x1_pkg::pxl_stream_t pxl_out
);

	localparam int AW    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	conv1x1_pkg::pixel_t mem [FIFO_DEPTH];

	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CNT_W-1:0] count;
	logic             read_en;
	logic             empty;
	logic             full;
	logic             rd_fire;

	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign rd_fire = read_en && !empty;

	always_ff @(posedge clk) begin
		if (wr.valid)
			mem[wr_ptr] <= wr.data;
		pxl_out.data <= mem[rd_ptr];
	end

	////////////////////////////////////////
	// Pointers, fill level, start latch
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			read_en       <= 1'b0;
			pxl_out.valid <= 1'b0;
		end else begin
			if (wr.valid)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr.valid, rd_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Stays set for the rest of the run
			if (count >= CNT_W'(START_LEVEL))
				read_en <= 1'b1;
			pxl_out.valid <= rd_fire;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wr.valid |-> (!full || rd_fire));

endmodule

// File: rtl/conv_channel_in_adder.sv
`timescale 1ns/10ps

module conv_channel_in_adder #(
	parameter int CHANNEL_NUM_IN = 4
) (
	input  logic                      clk,
	input  logic                      reset,
	input  conv1x1_pkg::prod_stream_t prod,
	output conv1x1_pkg::pxl_stream_t  sum_out
);

	localparam int CNT_W = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam conv1x1_pkg::acc_t SAT_HI = conv1x1_pkg::PIXEL_MAX;
	localparam conv1x1_pkg::acc_t SAT_LO = conv1x1_pkg::PIXEL_MIN;

	conv1x1_pkg::acc_t   acc;
	conv1x1_pkg::acc_t   acc_next;
	conv1x1_pkg::acc_t   shifted;
	conv1x1_pkg::pixel_t sat;
	logic                restart;
	logic [CNT_W-1:0]    grp_cnt;

	always_comb begin
		acc_next = restart ? prod.data : acc + prod.data;
		// Floor division by 2^FRAC_BITS
		shifted  = acc_next >>> conv1x1_pkg::FRAC_BITS;
		if (shifted > SAT_HI)
			sat = conv1x1_pkg::PIXEL_MAX;
		else if (shifted < SAT_LO)
			sat = conv1x1_pkg::PIXEL_MIN;
		else
			sat = shifted[conv1x1_pkg::DATA_WIDTH-1:0];
	end

	always_ff @(posedge clk) begin
		if (prod.valid)
			acc <= acc_next;
		sum_out.data <= sat;
		if (reset) begin
			restart       <= 1'b1;
			grp_cnt       <= '0;
			sum_out.valid <= 1'b0;
		end else begin
			sum_out.valid <= prod.valid && prod.last;
			if (prod.valid) begin
				restart <= prod.last;
				grp_cnt <= prod.last ? '0 : grp_cnt + 1'b1;
			end
		end
	end

	// Group marker from the multiplier lines up with CHANNEL_NUM_IN products
	a_group_len: assert property (@(posedge clk) disable iff (reset)
		(prod.valid && prod.last) |-> (grp_cnt == CNT_W'(CHANNEL_NUM_IN - 1)));

endmodule

// File: rtl/conv_weight_mult.sv
`timescale 1ns/10ps

module conv_weight_mult #(
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 2
) (
	input  logic                      clk,
	input  logic                      reset,
	input  conv1x1_pkg::pxl_stream_t  weight_in,
	input  conv1x1_pkg::pxl_stream_t  loop_in,
	output conv1x1_pkg::prod_stream_t prod
);

	localparam int W_NUM = CHANNEL_NUM_IN * CHANNEL_NUM_OUT;
	localparam int WP_W  = (W_NUM > 1) ? $clog2(W_NUM) : 1;
	localparam int CH_W  = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam int MUL_W = 2 * conv1x1_pkg::DATA_WIDTH;
	localparam int EXT_W = conv1x1_pkg::ACC_WIDTH - MUL_W;

	// Output-major weights, w[o][i] at o*CIN + i
	conv1x1_pkg::pixel_t weights [W_NUM];

	logic [WP_W-1:0] ld_ptr;
	logic [WP_W-1:0] rd_ptr;
	logic [CH_W-1:0] ch;
	logic            ch_last;
	logic            data_seen;

	logic signed [MUL_W-1:0] mult;

	assign ch_last = (ch == CH_W'(CHANNEL_NUM_IN - 1));
	assign mult    = loop_in.data * weights[rd_ptr];

	always_ff @(posedge clk) begin
		if (weight_in.valid)
			weights[ld_ptr] <= weight_in.data;
	end

	////////////////////////////////////////
	// Load and walk pointers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ld_ptr    <= '0;
			rd_ptr    <= '0;
			ch        <= '0;
			data_seen <= 1'b0;
		end else begin
			if (weight_in.valid)
				ld_ptr <= (ld_ptr == WP_W'(W_NUM - 1)) ? '0 : ld_ptr + 1'b1;
			// Replay order matches the weight layout
			if (loop_in.valid) begin
				rd_ptr    <= (rd_ptr == WP_W'(W_NUM - 1)) ? '0 : rd_ptr + 1'b1;
				ch        <= ch_last ? '0 : ch + 1'b1;
				data_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		prod.data <= {{EXT_W{mult[MUL_W-1]}}, mult};
		if (reset) begin
			prod.valid <= 1'b0;
			prod.last  <= 1'b0;
		end else begin
			prod.valid <= loop_in.valid;
			prod.last  <= loop_in.valid && ch_last;
		end
	end

	// Weights are a one-time preload
	a_no_late_weight: assert property (@(posedge clk) disable iff (reset)
		data_seen |-> !weight_in.valid);

endmodule

// File: rtl/conv_loop_data_in.sv
`timescale 1ns/10ps

module conv_loop_data_in #(
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 2
) (
	input  logic                     clk,
	input  logic                     reset,
	input  conv1x1_pkg::pxl_stream_t pxl_in,
	output conv1x1_pkg::pxl_stream_t loop_out
);

	localparam int CH_W = (CHANNEL_NUM_IN > 1) ? $clog2(CHANNEL_NUM_IN) : 1;
	localparam int OC_W = (CHANNEL_NUM_OUT > 1) ? $clog2(CHANNEL_NUM_OUT) : 1;

	// Ping-pong storage, one pixel vector per bank
	conv1x1_pkg::pixel_t bank [2][CHANNEL_NUM_IN];

	logic [CH_W-1:0] wr_ch;
	logic            wr_bank;
	logic [CH_W-1:0] rd_ch;
	logic [OC_W-1:0] rd_oc;
	logic            rd_bank;

	// Bank holds a full vector not yet fully replayed
	logic [1:0] pend;
	logic [1:0] set_mask;
	logic [1:0] clr_mask;
	logic       wr_done;
	logic       rd_done;

	assign wr_done = pxl_in.valid && (wr_ch == CH_W'(CHANNEL_NUM_IN - 1));
	assign rd_done = pend[rd_bank] && (rd_ch == CH_W'(CHANNEL_NUM_IN - 1)) &&
		(rd_oc == OC_W'(CHANNEL_NUM_OUT - 1));
	assign set_mask = wr_done ? (2'b01 << wr_bank) : 2'b00;
	assign clr_mask = rd_done ? (2'b01 << rd_bank) : 2'b00;

	always_ff @(posedge clk) begin
		if (pxl_in.valid)
			bank[wr_bank][wr_ch] <= pxl_in.data;
	end

	////////////////////////////////////////
	// Write and replay counters
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ch   <= '0;
			wr_bank <= 1'b0;
			rd_ch   <= '0;
			rd_oc   <= '0;
			rd_bank <= 1'b0;
			pend    <= 2'b00;
		end else begin
			pend <= (pend | set_mask) & ~clr_mask;
			if (pxl_in.valid) begin
				wr_ch <= wr_done ? '0 : wr_ch + 1'b1;
				if (wr_done)
					wr_bank <= ~wr_bank;
			end
			// Inner loop over input channels, outer over output channels
			if (pend[rd_bank]) begin
				if (rd_ch == CH_W'(CHANNEL_NUM_IN - 1)) begin
					rd_ch <= '0;
					rd_oc <= rd_done ? '0 : rd_oc + 1'b1;
				end else begin
					rd_ch <= rd_ch + 1'b1;
				end
				if (rd_done)
					rd_bank <= ~rd_bank;
			end
		end
	end

	always_comb begin
		loop_out.valid = pend[rd_bank];
		loop_out.data  = bank[rd_bank][rd_ch];
	end

	// Source must leave room for the full replay of the previous pixel
	a_bank_free: assert property (@(posedge clk) disable iff (reset)
		(pxl_in.valid && wr_ch == '0) |-> !pend[wr_bank]);

endmodule

// File: rtl/conv1x1_pkg.sv
package conv1x1_pkg;

	////////////////////////////////////////
	// Widths and fixed-point format
	////////////////////////////////////////

	// Pixel and weight width
	localparam int DATA_WIDTH = 16;

	// Fraction bits of the Q format
	localparam int FRAC_BITS  = 8;

	// Wide enough for a full CIN sum of 32-bit products
	localparam int ACC_WIDTH  = 40;

	typedef logic signed [DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;

	// Saturation limits of one output value
	localparam pixel_t PIXEL_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
	localparam pixel_t PIXEL_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

	////////////////////////////////////////
	// Streams
	////////////////////////////////////////

	// Pixels, weights, replayed channels and results
	typedef struct packed {
		logic   valid;
		pixel_t data;
	} pxl_stream_t;

	// Products headed for the channel adder
	typedef struct packed {
		logic valid;
		// Final input channel of a group
		logic last;
		acc_t data;
	} prod_stream_t;

endpackage
